/* files.f */
hw/riscv_pkg.sv
hw/mem_pkg.sv
hw/ram.sv
hw/store_align.sv
hw/load_extend.sv
hw/mem_ctrl.sv
hw/memory.sv
verification/memory_properties.sv
verification/memory_tb.sv

/* verification/memory_tb.sv */
// Testbench for the local memory with a data table under random rsp_ready,
// then a fetch table once every data response has come back.
// Loads only target words written earlier in the table, since the
// RAM starts undefined. Inputs change 1 unit after the rising edge.

module memory_tb import riscv_pkg::*, mem_pkg::*; ();

    typedef struct packed {
        mem_op_t op;
        word_t   addr;
        word_t   wdata;
        word_t   exp_rdata;
        logic    exp_err;
    } data_entry_t;

    typedef struct packed {
        word_t addr;
        word_t exp_word;
        logic  exp_err;
    } fetch_entry_t;

    localparam int DATA_N  = 36;
    localparam int FETCH_N = 7;
    localparam int TIMEOUT = (DATA_N + FETCH_N) * 20 * 4;

    // Expected merged words follow the little endian lane rule
    localparam data_entry_t DATA_TABLE [DATA_N] = '{
        '{STORE_WORD,         32'h0000_0000, 32'h1234_5678, 32'h0000_0000, 1'b0},
        '{LOAD_WORD,          32'h0000_0000, 32'h0000_0000, 32'h1234_5678, 1'b0},
        '{STORE_WORD,         32'h0000_0010, 32'hAABB_CCDD, 32'h0000_0000, 1'b0},
        '{STORE_BYTE,         32'h0000_0011, 32'hFFFF_FF5A, 32'h0000_0000, 1'b0},
        '{STORE_BYTE,         32'h0000_0013, 32'h0000_00E7, 32'h0000_0000, 1'b0},
        '{LOAD_WORD,          32'h0000_0010, 32'h0000_0000, 32'hE7BB_5ADD, 1'b0},
        '{STORE_HALF,         32'h0000_0012, 32'h1234_9876, 32'h0000_0000, 1'b0},
        '{STORE_HALF,         32'h0000_0010, 32'h0000_C3A5, 32'h0000_0000, 1'b0},
        '{LOAD_WORD,          32'h0000_0010, 32'h0000_0000, 32'h9876_C3A5, 1'b0},
        '{STORE_BYTE,         32'h0000_0010, 32'h0000_0011, 32'h0000_0000, 1'b0},
        '{STORE_BYTE,         32'h0000_0012, 32'h0000_0022, 32'h0000_0000, 1'b0},
        '{LOAD_WORD,          32'h0000_0010, 32'h0000_0000, 32'h9822_C311, 1'b0},
        '{STORE_WORD,         32'h0000_0020, 32'h80F1_7F01, 32'h0000_0000, 1'b0},
        '{LOAD_BYTE,          32'h0000_0020, 32'h0000_0000, 32'h0000_0001, 1'b0},
        '{LOAD_BYTE,          32'h0000_0021, 32'h0000_0000, 32'h0000_007F, 1'b0},
        '{LOAD_BYTE,          32'h0000_0022, 32'h0000_0000, 32'hFFFF_FFF1, 1'b0},
        '{LOAD_BYTE,          32'h0000_0023, 32'h0000_0000, 32'hFFFF_FF80, 1'b0},
        '{LOAD_BYTE_UNSIGNED, 32'h0000_0020, 32'h0000_0000, 32'h0000_0001, 1'b0},
        '{LOAD_BYTE_UNSIGNED, 32'h0000_0021, 32'h0000_0000, 32'h0000_007F, 1'b0},
        '{LOAD_BYTE_UNSIGNED, 32'h0000_0022, 32'h0000_0000, 32'h0000_00F1, 1'b0},
        '{LOAD_BYTE_UNSIGNED, 32'h0000_0023, 32'h0000_0000, 32'h0000_0080, 1'b0},
        '{LOAD_HALF,          32'h0000_0020, 32'h0000_0000, 32'h0000_7F01, 1'b0},
        '{LOAD_HALF,          32'h0000_0022, 32'h0000_0000, 32'hFFFF_80F1, 1'b0},
        '{LOAD_HALF_UNSIGNED, 32'h0000_0020, 32'h0000_0000, 32'h0000_7F01, 1'b0},
        '{LOAD_HALF_UNSIGNED, 32'h0000_0022, 32'h0000_0000, 32'h0000_80F1, 1'b0},
        '{LOAD_WORD,          32'h0000_1000, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{STORE_WORD,         32'h0000_1000, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1},
        '{LOAD_BYTE,          32'h0000_1003, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{STORE_WORD,         32'hFFFF_FFFC, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1},
        '{STORE_WORD,         32'h0000_0012, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1},
        '{STORE_HALF,         32'h0000_0011, 32'h0000_BEEF, 32'h0000_0000, 1'b1},
        '{LOAD_HALF,          32'h0000_0023, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{LOAD_WORD,          32'h0000_0021, 32'h0000_0000, 32'h0000_0000, 1'b1},
        '{LOAD_HALF_UNSIGNED, 32'h0000_0021, 32'h0000_0000, 32'h0000_0000, 1'b1},
        // Rejected stores above must not have touched these words
        '{LOAD_WORD,          32'h0000_0010, 32'h0000_0000, 32'h9822_C311, 1'b0},
        '{LOAD_WORD,          32'h0000_0000, 32'h0000_0000, 32'h1234_5678, 1'b0}
    };

    // Fetch data is only checked where no error is expected
    localparam fetch_entry_t FETCH_TABLE [FETCH_N] = '{
        '{32'h0000_0000, 32'h1234_5678, 1'b0},
        '{32'h0000_0010, 32'h9822_C311, 1'b0},
        '{32'h0000_0020, 32'h80F1_7F01, 1'b0},
        '{32'h0000_0002, 32'h0000_0000, 1'b1},
        '{32'h0000_0011, 32'h0000_0000, 1'b1},
        '{32'h0000_1000, 32'h0000_0000, 1'b1},
        '{32'hFFFF_FFFC, 32'h0000_0000, 1'b1}
    };

    logic    clk;
    logic    rst_n;
    logic    dmem_valid;
    mem_op_t dmem_op;
    word_t   dmem_addr;
    word_t   dmem_wdata;
    logic    dmem_ready;
    logic    rsp_valid;
    logic    rsp_ready;
    word_t   rsp_rdata;
    logic    rsp_error;
    word_t   imem_addr;
    word_t   imem_rdata;
    logic    imem_error;

    int word_errors   = 0;
    int flag_errors   = 0;
    int other_errors  = 0;
    int assert_errors = 0;
    int rsp_count     = 0;

    memory dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_valid (dmem_valid),
        .dmem_op    (dmem_op),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_ready (dmem_ready),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_rdata  (rsp_rdata),
        .rsp_error  (rsp_error),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_error (imem_error)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            word_errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Called 1 unit after an edge, returns 1 unit after the accepting edge
    task automatic send_request(input data_entry_t entry);
        dmem_valid = 1'b1;
        dmem_op    = entry.op;
        dmem_addr  = entry.addr;
        dmem_wdata = entry.wdata;
        @(posedge clk);
        while (!dmem_ready) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic run_fetch_table();
        foreach (FETCH_TABLE[i]) begin
            imem_addr = FETCH_TABLE[i].addr;
            @(posedge clk);
            #1;
            check_flag($sformatf("imem_error[%0d]", i), imem_error, FETCH_TABLE[i].exp_err);
            if (!FETCH_TABLE[i].exp_err) begin
                check_word($sformatf("imem_rdata[%0d]", i), imem_rdata,
                           FETCH_TABLE[i].exp_word);
            end
        end
    endtask

    // Random back-pressure on the response port
    initial begin
        void'($urandom(32'h96d0));
        forever begin
            @(posedge clk);
            #1 rsp_ready = ($urandom() % 4) != 0;
        end
    end

    // Responses come back in table order
    initial begin
        forever begin
            @(posedge clk);
            if (rst_n && rsp_valid && rsp_ready) begin
                if (rsp_count >= DATA_N) begin
                    other_errors++;
                    $display("Response received with no request left to match it");
                end else begin
                    check_word($sformatf("rsp_rdata[%0d]", rsp_count), rsp_rdata,
                               DATA_TABLE[rsp_count].exp_rdata);
                    check_flag($sformatf("rsp_error[%0d]", rsp_count), rsp_error,
                               DATA_TABLE[rsp_count].exp_err);
                end
                rsp_count++;
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout after %0d time units, %0d of %0d responses received",
                 TIMEOUT, rsp_count, DATA_N);
        $display("test failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        dmem_valid = 1'b0;
        dmem_op    = LOAD_STORE_NONE;
        dmem_addr  = '0;
        dmem_wdata = '0;
        rsp_ready  = 1'b0;
        imem_addr  = '0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        foreach (DATA_TABLE[i]) begin
            send_request(DATA_TABLE[i]);
        end
        dmem_valid = 1'b0;
        dmem_op    = LOAD_STORE_NONE;

        wait (rsp_count >= DATA_N);
        @(posedge clk);
        #1;
        run_fetch_table();

        assert_errors = dut_i.ctrl_i.props_i.fail_count;
        $display("Errors: word %0d, flag %0d, other %0d, assertion %0d", word_errors,
                 flag_errors, other_errors, assert_errors);
        if (word_errors + flag_errors + other_errors + assert_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verification/memory_properties.sv */
// Handshake and RAM enable properties of the memory controller.
// Bound into mem_ctrl and disabled while rst_n is low.

module memory_properties import riscv_pkg::*, mem_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input mem_op_t dmem_op,
    input word_t   dmem_addr,
    input logic    ram_ena,
    input logic    rsp_valid,
    input logic    rsp_ready,
    input logic    rsp_error,
    input word_t   rsp_rdata
);

    // Number of assertion failures
    int   fail_count = 0;
    logic addr_bad;

    // Address out of range or not aligned to the access size
    assign addr_bad = (dmem_addr >= MEM_BYTES)
        || ((dmem_op inside {LOAD_HALF, LOAD_HALF_UNSIGNED, STORE_HALF}) && dmem_addr[0])
        || ((dmem_op inside {LOAD_WORD, STORE_WORD}) && (dmem_addr[1:0] != 2'b00));

    // A held response only leaves through a handshake
    rsp_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> rsp_valid)
        else begin
            fail_count++;
            $error("rsp_valid dropped without a handshake");
        end

    // Payload frozen under back-pressure
    rsp_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid && !rsp_ready) |=> ($stable(rsp_rdata) && $stable(rsp_error)))
        else begin
            fail_count++;
            $error("response payload changed under back-pressure");
        end

    ram_ena_no_error: assert property (@(posedge clk) disable iff (!rst_n)
        ram_ena |-> !addr_bad)
        else begin
            fail_count++;
            $error("RAM enabled for an erroring request");
        end

endmodule

bind mem_ctrl memory_properties props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .dmem_op   (dmem_op),
    .dmem_addr (dmem_addr),
    .ram_ena   (ram_ena),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_error (rsp_error),
    .rsp_rdata (rsp_rdata)
);

/* hw/memory.sv */
// Local memory of the RV32 core on one block RAM.
// Data port: valid/ready request, one response per request in order.
// Fetch port: one word per cycle, no handshake, one cycle latency.
// Only MEM_ADDR_WIDTH word address bits reach the RAM; the upper
// bits are range checked in the controller.

module memory import riscv_pkg::*, mem_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    dmem_valid,
    input  mem_op_t dmem_op,
    input  word_t   dmem_addr,
    input  word_t   dmem_wdata,
    output logic    dmem_ready,

    output logic    rsp_valid,
    input  logic    rsp_ready,
    output word_t   rsp_rdata,
    output logic    rsp_error,

    input  word_t   imem_addr,
    output word_t   imem_rdata,
    output logic    imem_error
);

    logic       ram_ena;
    lane_en_t   ram_wea;
    lane_en_t   lanes;
    word_t      ram_dia;
    word_t      ram_doa;
    word_t      ext_rdata;
    mem_op_t    load_op;
    logic [1:0] load_off;

    mem_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_valid (dmem_valid),
        .dmem_op    (dmem_op),
        .dmem_addr  (dmem_addr),
        .dmem_ready (dmem_ready),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_error  (rsp_error),
        .rsp_rdata  (rsp_rdata),
        .ext_rdata  (ext_rdata),
        .ram_ena    (ram_ena),
        .lanes      (lanes),
        .ram_wea    (ram_wea),
        .load_op    (load_op),
        .load_off   (load_off),
        .imem_addr  (imem_addr),
        .imem_error (imem_error)
    );

    store_align align_i (
        .op       (dmem_op),
        .byte_off (dmem_addr[1:0]),
        .wdata    (dmem_wdata),
        .aligned  (ram_dia),
        .lanes    (lanes)
    );

    load_extend extend_i (
        .op       (load_op),
        .byte_off (load_off),
        .raw      (ram_doa),
        .rdata    (ext_rdata)
    );

    // Port B enable is left at its default inside the RAM
    ram #(
        .DATA_WIDTH ($bits(word_t)),
        .ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) ram_i (
        .clk   (clk),
        .ena   (ram_ena),
        .wea   (ram_wea),
        .addra (dmem_addr[MEM_ADDR_WIDTH+1:2]),
        .dia   (ram_dia),
        .doa   (ram_doa),
        .addrb (imem_addr[MEM_ADDR_WIDTH+1:2]),
        .dob   (imem_rdata)
    );

endmodule

/* hw/mem_ctrl.sv */
// Request checks, RAM enables and the single response slot.
// A request is accepted when dmem_valid and dmem_ready are high.
// Out of range or misaligned accesses get rsp_error and never
// enable the RAM, so erroring stores write nothing.
// The response slot holds one result; the RAM output is frozen
// while it waits, so load data stays valid under back-pressure.

module mem_ctrl import riscv_pkg::*, mem_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       dmem_valid,
    input  mem_op_t    dmem_op,
    input  word_t      dmem_addr,
    output logic       dmem_ready,

    output logic       rsp_valid,
    input  logic       rsp_ready,
    output logic       rsp_error,
    output word_t      rsp_rdata,

    input  word_t      ext_rdata,

    output logic       ram_ena,
    input  lane_en_t   lanes,
    output lane_en_t   ram_wea,

    output mem_op_t    load_op,
    output logic [1:0] load_off,

    input  word_t      imem_addr,
    output logic       imem_error
);

    logic run;
    logic accept;
    logic req_is_load;
    logic req_misaligned;
    logic req_out_of_range;
    logic req_error;
    logic rsp_is_load;

    // Size and alignment of the incoming op
    always_comb begin
        req_is_load    = 1'b0;
        req_misaligned = 1'b0;

        unique case (dmem_op)
            LOAD_BYTE, LOAD_BYTE_UNSIGNED: begin
                req_is_load = 1'b1;
            end
            LOAD_HALF, LOAD_HALF_UNSIGNED: begin
                req_is_load    = 1'b1;
                req_misaligned = dmem_addr[0];
            end
            LOAD_WORD: begin
                req_is_load    = 1'b1;
                req_misaligned = |dmem_addr[1:0];
            end
            STORE_HALF: begin
                req_misaligned = dmem_addr[0];
            end
            STORE_WORD: begin
                req_misaligned = |dmem_addr[1:0];
            end
            default: begin
                req_misaligned = 1'b0;
            end
        endcase
    end

    assign req_out_of_range = dmem_addr >= MEM_BYTES;
    assign req_error        = req_misaligned || req_out_of_range;

    // Free slot, or the held response leaves this cycle
    assign dmem_ready = run && (!rsp_valid || rsp_ready);
    assign accept     = dmem_valid && dmem_ready;

    assign ram_ena = accept && !req_error;
    assign ram_wea = ram_ena ? lanes : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (accept) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Response payload, captured at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            load_op     <= dmem_op;
            load_off    <= dmem_addr[1:0];
            rsp_error   <= req_error;
            rsp_is_load <= req_is_load;
        end
    end

    assign rsp_rdata = (rsp_is_load && !rsp_error) ? ext_rdata : '0;

    // Fetch check lines up with the RAM port B output
    always_ff @(posedge clk) begin
        imem_error <= (|imem_addr[1:0]) || (imem_addr >= MEM_BYTES);
    end

endmodule

/* hw/load_extend.sv */
// Picks the loaded byte or halfword out of a RAM word and extends it.
// op and byte_off must be the values registered at acceptance,
// so they line up with the RAM output one cycle later.
// Non-load ops return zero.

module load_extend import riscv_pkg::*, mem_pkg::*; (
    input  mem_op_t    op,
    input  logic [1:0] byte_off,
    input  word_t      raw,
    output word_t      rdata
);

    mem_word_u   word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign word = raw;

    // Lane selection
    always_comb begin
        sel_byte = word.bytes[byte_off];
        sel_half = word.halves[byte_off[1]];
    end

    always_comb begin
        unique case (op)
            LOAD_BYTE: begin
                rdata = {{24{sel_byte[7]}}, sel_byte};
            end

            LOAD_HALF: begin
                rdata = {{16{sel_half[15]}}, sel_half};
            end

            LOAD_WORD: begin
                rdata = word;
            end

            LOAD_BYTE_UNSIGNED: begin
                rdata = {24'h000000, sel_byte};
            end

            LOAD_HALF_UNSIGNED: begin
                rdata = {16'h0000, sel_half};
            end

            default: begin
                // Stores and idle give zero
                rdata = '0;
            end
        endcase
    end

endmodule

/* hw/store_align.sv */
// Places store data on the addressed byte lanes.
// Half accesses use only byte_off[1]; misaligned stores are
// caught by the controller, which masks the lanes.
// Non-store ops give no lanes and zero data.

module store_align import riscv_pkg::*, mem_pkg::*; (
    input  mem_op_t    op,
    input  logic [1:0] byte_off,
    input  word_t      wdata,
    output word_t      aligned,
    output lane_en_t   lanes
);

    mem_word_u word;

    always_comb begin
        word  = '0;
        lanes = '0;

        unique case (op)
            STORE_BYTE: begin
                word.bytes[byte_off] = wdata[7:0];
                lanes[byte_off]      = 1'b1;
            end

            STORE_HALF: begin
                word.halves[byte_off[1]] = wdata[15:0];
                if (byte_off[1]) begin
                    lanes = 4'b1100;
                end else begin
                    lanes = 4'b0011;
                end
            end

            STORE_WORD: begin
                word  = wdata;
                lanes = '1;
            end

            default: begin
                // Loads and idle leave the RAM untouched
                lanes = '0;
            end
        endcase
    end

    assign aligned = word;

endmodule

/* hw/ram.sv */
// Dual-port block RAM in inferable style.
// Port A reads first, then writes the lanes set in wea.
// Port B is read only and is enabled every cycle unless driven.
// DATA_WIDTH must split evenly into the lanes of lane_en_t.
// Contents start undefined, there is no reset and no init image.

module ram import mem_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = MEM_ADDR_WIDTH
) (
    input  logic                  clk,

    input  logic                  ena,
    input  lane_en_t              wea,
    input  logic [ADDR_WIDTH-1:0] addra,
    input  logic [DATA_WIDTH-1:0] dia,
    output logic [DATA_WIDTH-1:0] doa,

    input  logic                  enb = 1'b1,
    input  logic [ADDR_WIDTH-1:0] addrb,
    output logic [DATA_WIDTH-1:0] dob
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Port A, old word comes out while the new lanes are written
    always_ff @(posedge clk) begin
        if (ena) begin
            doa <= mem[addra];
            for (int i = 0; i < $bits(lane_en_t); i++) begin
                if (wea[i]) begin
                    mem[addra][i*(DATA_WIDTH/$bits(lane_en_t)) +: DATA_WIDTH/$bits(lane_en_t)]
                        <= dia[i*(DATA_WIDTH/$bits(lane_en_t)) +: DATA_WIDTH/$bits(lane_en_t)];
                end
            end
        end
    end

    // Port B
    always_ff @(posedge clk) begin
        if (enb) begin
            dob <= mem[addrb];
        end
    end

endmodule

/* hw/mem_pkg.sv */
// Geometry and lane types of the local block RAM.
// The RAM holds 32-bit words with four byte lanes, little endian.
// MEM_BYTES is the only range limit, there is no address wrap.

package mem_pkg;

    // Word address width of the RAM
    localparam int unsigned MEM_ADDR_WIDTH = 10;

    // Byte size of the RAM, used for range checks
    localparam int unsigned MEM_BYTES = 4 * (2 ** MEM_ADDR_WIDTH);

    // One RAM word seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

    // Byte write enable, bit i covers bits 8*i+7 down to 8*i
    typedef logic [3:0] lane_en_t;

endpackage

/* hw/riscv_pkg.sv */
// ISA-level types shared by the memory and the core side.
// Only the RV32 load and store subset is described here.
// The op code is 4 bits wide and LOAD_STORE_NONE marks an idle slot.

package riscv_pkg;

    // Architectural data word of RV32
    typedef logic [31:0] word_t;

    // Memory operation requested by the core
    typedef enum logic [3:0] {
        LOAD_STORE_NONE,

        // Loads with sign extension
        LOAD_BYTE,
        LOAD_HALF,
        LOAD_WORD,

        // Loads with zero extension
        LOAD_BYTE_UNSIGNED,
        LOAD_HALF_UNSIGNED,

        // Stores write only the covered byte lanes
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD
    } mem_op_t;

endpackage
